// ==== common/clint_settings.svh ====
//============================================================
// CLINT settings
// Address map, mtime prescaler and reset values shared by
// the controller RTL and its testbench
//============================================================

`ifndef CLINT_SETTINGS_SVH
`define CLINT_SETTINGS_SVH

//============================================================
// Register offsets on paddr[15:0], one 32-bit word each
//============================================================

// Machine software interrupt pending
`define CLINT_MSIP_ADDR       16'h0000
// Machine time compare, low and high halves
`define CLINT_MTIMECMP_ADDR   16'h4000
`define CLINT_MTIMECMPH_ADDR  16'h4004
// Free-running time, low and high halves
`define CLINT_MTIME_ADDR      16'hBFF8
`define CLINT_MTIMEH_ADDR     16'hBFFC
// Supervisor software interrupt pending
`define CLINT_SSIP_ADDR       16'hC000
// Supervisor time compare, low and high halves
`define CLINT_STIMECMP_ADDR   16'hD000
`define CLINT_STIMECMPH_ADDR  16'hD004

//============================================================
// Timing and reset values
//============================================================

// Clocks per mtime tick
`define CLINT_TICK_DIV        4
// Compare halves come up all ones so no timer fires early
`define CLINT_CMP_RESET       32'hFFFF_FFFF

`endif

// ==== common/clint_pkg.sv ====
//============================================================
// CLINT package
// Bus structs, register write strobe and interrupt bundle
//============================================================

`include "clint_settings.svh"

package clint_pkg;

  // Register index, decoded once in the APB FSM
  typedef enum logic [3:0] {
    REG_MSIP      = 4'd0,
    REG_MTIMECMP  = 4'd1,
    REG_MTIMECMPH = 4'd2,
    REG_MTIME     = 4'd3,
    REG_MTIMEH    = 4'd4,
    REG_SSIP      = 4'd5,
    REG_STIMECMP  = 4'd6,
    REG_STIMECMPH = 4'd7,
    REG_NONE      = 4'd15
  } clint_reg_e;

  // APB request from the master, 69 bits
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    // 00 user, 01 supervisor, 11 machine
    logic [1:0]  pprot;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response back to the master, 34 bits
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Write strobe to the register blocks, 37 bits
  typedef struct packed {
    logic        wen;
    clint_reg_e  idx;
    logic [31:0] data;
  } reg_wr_t;

  // Interrupt lines to the hart
  typedef struct packed {
    logic ms;
    logic mt;
    logic ss;
    logic st;
  } clint_irq_t;

  // Full 64-bit compare value after reset
  localparam logic [63:0] CLINT_CMP_ALL_ONES = {2{`CLINT_CMP_RESET}};

endpackage

// ==== hdl/clint_apb_fsm.sv ====
//============================================================
// CLINT APB slave
// Two-phase transfer FSM with address and privilege checks,
// write strobe generation and read data select
//============================================================

`include "clint_settings.svh"

module clint_apb_fsm
  import clint_pkg::*;
(
  input  logic        clint_clk,
  input  logic        cpurst_b,
  input  apb_req_t    apb_req,
  input  logic [31:0] reg_rdata,
  input  logic [63:0] mtime,
  output apb_rsp_t    apb_rsp,
  output reg_wr_t     reg_wr
);

  localparam logic ST_IDLE   = 1'b0;
  localparam logic ST_ACCESS = 1'b1;

  logic        state_q;
  logic        state_d;
  clint_reg_e  dec_idx;
  clint_reg_e  idx_q;
  logic        err_q;
  logic        dec_err;
  logic        setup;
  logic        access;
  logic        mach_mode;
  logic        user_mode;
  logic        m_region;
  logic        s_region;
  logic [31:0] rdata;

  //============================================================
  // Setup phase decode
  //============================================================

  // Only the low half of paddr selects a register
  always_comb
  begin
    case (apb_req.paddr[15:0])
      `CLINT_MSIP_ADDR:      dec_idx = REG_MSIP;
      `CLINT_MTIMECMP_ADDR:  dec_idx = REG_MTIMECMP;
      `CLINT_MTIMECMPH_ADDR: dec_idx = REG_MTIMECMPH;
      `CLINT_MTIME_ADDR:     dec_idx = REG_MTIME;
      `CLINT_MTIMEH_ADDR:    dec_idx = REG_MTIMEH;
      `CLINT_SSIP_ADDR:      dec_idx = REG_SSIP;
      `CLINT_STIMECMP_ADDR:  dec_idx = REG_STIMECMP;
      `CLINT_STIMECMPH_ADDR: dec_idx = REG_STIMECMPH;
      default:               dec_idx = REG_NONE;
    endcase
  end

  // Privilege level from pprot
  assign mach_mode = (apb_req.pprot == 2'b11);
  assign user_mode = (apb_req.pprot == 2'b00);

  // Machine region includes mtime
  assign m_region = dec_idx inside {REG_MSIP, REG_MTIMECMP, REG_MTIMECMPH,
                                    REG_MTIME, REG_MTIMEH};
  assign s_region = dec_idx inside {REG_SSIP, REG_STIMECMP, REG_STIMECMPH};

  // Unmapped, or privilege too low for the region
  assign dec_err = (dec_idx == REG_NONE)
                || (m_region && !mach_mode)
                || (s_region && user_mode);

  assign setup  = (state_q == ST_IDLE) && apb_req.psel && !apb_req.penable;
  assign access = (state_q == ST_ACCESS);

  //============================================================
  // State and captured decode
  //============================================================

  always_comb
  begin
    case (state_q)
      ST_IDLE:   state_d = setup ? ST_ACCESS : ST_IDLE;
      // No wait states, access always lasts one cycle
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clint_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      state_q <= ST_IDLE;
      idx_q   <= REG_NONE;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (setup)
      begin
        idx_q <= dec_idx;
        err_q <= dec_err;
      end
    end
  end

  //============================================================
  // Access phase response
  //============================================================

  // mtime lives in the counter, everything else in the regfile
  always_comb
  begin
    rdata = 32'h0;
    if (access && !err_q)
    begin
      case (idx_q)
        REG_MTIME:  rdata = mtime[31:0];
        REG_MTIMEH: rdata = mtime[63:32];
        default:    rdata = reg_rdata;
      endcase
    end
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access && err_q;

  // Strobe lands on the edge that ends the access cycle
  // Index doubles as the read select for the regfile
  assign reg_wr.wen  = access && apb_req.pwrite && !err_q;
  assign reg_wr.idx  = idx_q;
  assign reg_wr.data = apb_req.pwdata;

  //============================================================
  // Protocol checks
  //============================================================

  // A setup cycle never arrives with penable already high
  a_no_penable_in_idle: assert property (
    @(posedge clint_clk) disable iff (!cpurst_b)
    (state_q == ST_IDLE) |-> !apb_req.penable
  );

  // Write strobe only inside a proper access phase, never with an error
  a_wen_in_access: assert property (
    @(posedge clint_clk) disable iff (!cpurst_b)
    reg_wr.wen |-> (apb_req.psel && apb_req.penable && !apb_rsp.pslverr)
  );

endmodule

// ==== hdl/clint_mtime_counter.sv ====
//============================================================
// CLINT mtime counter
// 64-bit time base advanced by a clock prescaler, with
// 32-bit half loads from the bus
//============================================================

`include "clint_settings.svh"

module clint_mtime_counter
  import clint_pkg::*;
(
  input  logic        clint_clk,
  input  logic        cpurst_b,
  input  reg_wr_t     reg_wr,
  output logic [63:0] mtime
);

  localparam int unsigned TICK_DIV = `CLINT_TICK_DIV;
  // Keep at least one prescaler bit for a divide of one
  localparam int unsigned PRE_W    = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PRE_W-1:0] presc_q;
  logic [63:0]      mtime_q;
  logic             tick;
  logic             wr_lo;
  logic             wr_hi;

  // Half-word loads
  assign wr_lo = reg_wr.wen && (reg_wr.idx == REG_MTIME);
  assign wr_hi = reg_wr.wen && (reg_wr.idx == REG_MTIMEH);

  // Last clock of each prescaler period
  assign tick = (presc_q == PRE_W'(TICK_DIV - 1));

  always_ff @(posedge clint_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      presc_q <= '0;
      mtime_q <= 64'h0;
    end
    else if (wr_lo || wr_hi)
    begin
      // Load wins over a tick, prescaler starts over
      presc_q <= '0;
      if (wr_lo)
        mtime_q[31:0] <= reg_wr.data;
      if (wr_hi)
        mtime_q[63:32] <= reg_wr.data;
    end
    else if (tick)
    begin
      presc_q <= '0;
      mtime_q <= mtime_q + 64'd1;
    end
    else
    begin
      presc_q <= presc_q + PRE_W'(1);
    end
  end

  assign mtime = mtime_q;

  // Time only moves backwards through a bus load
  a_mtime_monotonic: assert property (
    @(posedge clint_clk) disable iff (!cpurst_b)
    !(wr_lo || wr_hi) |=> (mtime_q >= $past(mtime_q))
  );

endmodule

// ==== hdl/clint_regfile.sv ====
//============================================================
// CLINT register file
// Software pending bits, machine and supervisor time
// compares, and the read select for them
//============================================================

`include "clint_settings.svh"

module clint_regfile
  import clint_pkg::*;
(
  input  logic        clint_clk,
  input  logic        cpurst_b,
  input  reg_wr_t     reg_wr,
  input  clint_reg_e  rd_idx,
  output logic [31:0] rdata,
  output logic [63:0] mtimecmp,
  output logic [63:0] stimecmp,
  output logic [1:0]  sip
);

  logic        msip_q;
  logic        ssip_q;
  logic [31:0] mtimecmp_lo_q;
  logic [31:0] mtimecmp_hi_q;
  logic [31:0] stimecmp_lo_q;
  logic [31:0] stimecmp_hi_q;

  //============================================================
  // Software interrupt pending
  //============================================================

  // Only bit 0 of the write data is kept
  always_ff @(posedge clint_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      msip_q <= 1'b0;
      ssip_q <= 1'b0;
    end
    else if (reg_wr.wen)
    begin
      if (reg_wr.idx == REG_MSIP)
        msip_q <= reg_wr.data[0];
      if (reg_wr.idx == REG_SSIP)
        ssip_q <= reg_wr.data[0];
    end
  end

  //============================================================
  // Time compare halves
  //============================================================

  always_ff @(posedge clint_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      mtimecmp_lo_q <= `CLINT_CMP_RESET;
      mtimecmp_hi_q <= `CLINT_CMP_RESET;
      stimecmp_lo_q <= `CLINT_CMP_RESET;
      stimecmp_hi_q <= `CLINT_CMP_RESET;
    end
    else if (reg_wr.wen)
    begin
      case (reg_wr.idx)
        REG_MTIMECMP:  mtimecmp_lo_q <= reg_wr.data;
        REG_MTIMECMPH: mtimecmp_hi_q <= reg_wr.data;
        REG_STIMECMP:  stimecmp_lo_q <= reg_wr.data;
        REG_STIMECMPH: stimecmp_hi_q <= reg_wr.data;
        // Pending bits and mtime are handled elsewhere
        default:       ;
      endcase
    end
  end

  //============================================================
  // Read select and outputs
  //============================================================

  // mtime indices read as zero here, the FSM picks the counter
  always_comb
  begin
    case (rd_idx)
      REG_MSIP:      rdata = {31'h0, msip_q};
      REG_SSIP:      rdata = {31'h0, ssip_q};
      REG_MTIMECMP:  rdata = mtimecmp_lo_q;
      REG_MTIMECMPH: rdata = mtimecmp_hi_q;
      REG_STIMECMP:  rdata = stimecmp_lo_q;
      REG_STIMECMPH: rdata = stimecmp_hi_q;
      default:       rdata = 32'h0;
    endcase
  end

  assign mtimecmp = {mtimecmp_hi_q, mtimecmp_lo_q};
  assign stimecmp = {stimecmp_hi_q, stimecmp_lo_q};

  // Machine in bit 1, supervisor in bit 0
  assign sip = {msip_q, ssip_q};

endmodule

// ==== hdl/clint_irq_gen.sv ====
//============================================================
// CLINT interrupt generator
// Registered software and timer interrupt lines
//============================================================

module clint_irq_gen
  import clint_pkg::*;
(
  input  logic        clint_clk,
  input  logic        cpurst_b,
  input  logic [63:0] mtime,
  input  logic [63:0] mtimecmp,
  input  logic [63:0] stimecmp,
  input  logic [1:0]  sip,
  output clint_irq_t  irq
);

  clint_irq_t irq_d;
  clint_irq_t irq_q;

  // Software lines follow the pending bits
  assign irq_d.ms = sip[1];
  assign irq_d.ss = sip[0];

  // Unsigned compare, timer fires once mtime reaches compare
  assign irq_d.mt = (mtime >= mtimecmp);
  assign irq_d.st = (mtime >= stimecmp);

  // One cycle behind the pending bits and the compare inputs
  always_ff @(posedge clint_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      irq_q <= '0;
    else
      irq_q <= irq_d;
  end

  assign irq = irq_q;

  //============================================================
  // Checks
  //============================================================

  // Fresh mtime against reset compare keeps the timer quiet
  a_mt_quiet_after_reset: assert property (
    @(posedge clint_clk)
    ($rose(cpurst_b) && (mtimecmp == CLINT_CMP_ALL_ONES)) |=> !irq.mt
  );

endmodule

// ==== hdl/clint_top.sv ====
//============================================================
// CLINT top
// Single-hart core-local interrupt controller on APB
//============================================================

module clint_top
  import clint_pkg::*;
(
  input  logic        clint_clk,
  input  logic        cpurst_b,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  output clint_irq_t  irq,
  output logic [63:0] clint_time
);

  reg_wr_t     reg_wr;
  logic [31:0] reg_rdata;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [63:0] stimecmp;
  logic [1:0]  sip;

  // Bus front end
  clint_apb_fsm i_apb_fsm (
    .clint_clk (clint_clk),
    .cpurst_b  (cpurst_b),
    .apb_req   (apb_req),
    .reg_rdata (reg_rdata),
    .mtime     (mtime),
    .apb_rsp   (apb_rsp),
    .reg_wr    (reg_wr)
  );

  // Registered index also selects the read word
  clint_regfile i_regfile (
    .clint_clk (clint_clk),
    .cpurst_b  (cpurst_b),
    .reg_wr    (reg_wr),
    .rd_idx    (reg_wr.idx),
    .rdata     (reg_rdata),
    .mtimecmp  (mtimecmp),
    .stimecmp  (stimecmp),
    .sip       (sip)
  );

  // Local time base
  clint_mtime_counter i_mtime_counter (
    .clint_clk (clint_clk),
    .cpurst_b  (cpurst_b),
    .reg_wr    (reg_wr),
    .mtime     (mtime)
  );

  // Interrupt lines to the hart
  clint_irq_gen i_irq_gen (
    .clint_clk (clint_clk),
    .cpurst_b  (cpurst_b),
    .mtime     (mtime),
    .mtimecmp  (mtimecmp),
    .stimecmp  (stimecmp),
    .sip       (sip),
    .irq       (irq)
  );

  assign clint_time = mtime;

endmodule

// ==== testbench/tb_clk_gen.sv ====
//============================================================
// Testbench clock and reset
// Free-running clock and active-low reset for a few cycles
//============================================================

module tb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clint_clk,
  output logic cpurst_b
);

  // Clock toggles every half period
  initial
  begin
    clint_clk = 1'b0;
    forever #(PERIOD / 2) clint_clk = ~clint_clk;
  end

  // Reset held low, released on a rising edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge clint_clk);
    cpurst_b <= 1'b1;
  end

endmodule

// ==== testbench/clint_tb.sv ====
//============================================================
// CLINT testbench
// APB stimulus, shadow register model, per-cycle interrupt
// compare and a watchdog
//============================================================

`include "clint_settings.svh"

module clint_tb
  import clint_pkg::*;
;

  localparam int NUM_XFERS       = 200;
  localparam int WATCHDOG_CYCLES = NUM_XFERS * 4 + 1500;
  localparam int TICK_DIV        = `CLINT_TICK_DIV;
  localparam int RISE_LIMIT      = 64 * TICK_DIV;

  logic        clint_clk;
  logic        cpurst_b;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  clint_irq_t  irq;
  logic [63:0] clint_time;

  integer      seed = 32'hbeb98512;

  // Shadow model of the register state
  logic        sh_msip = 1'b0;
  logic        sh_ssip = 1'b0;
  logic [63:0] sh_mcmp = CLINT_CMP_ALL_ONES;
  logic [63:0] sh_scmp = CLINT_CMP_ALL_ONES;
  int unsigned mtime_wr_cnt = 0;
  longint unsigned mtime_wr_cycle = 0;
  longint unsigned cycle_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clint_clk (clint_clk),
    .cpurst_b  (cpurst_b)
  );

  clint_top i_dut (
    .clint_clk  (clint_clk),
    .cpurst_b   (cpurst_b),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .irq        (irq),
    .clint_time (clint_time)
  );

  always @(posedge clint_clk)
    cycle_cnt <= cycle_cnt + 1;

  //============================================================
  // Reporting and compare tasks
  //============================================================

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s got %08h expected %08h",
                               $time, what, got, exp));
  endtask

  task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input logic with_data,
                           input string what);
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr
        || (with_data && got.prdata !== exp.prdata))
      report_failure($sformatf("Mismatch at %0t: %s got rdy %b err %b data %08h, exp %b %b %08h",
                               $time, what, got.pready, got.pslverr, got.prdata,
                               exp.pready, exp.pslverr, exp.prdata));
  endtask

  task automatic check_irq(input clint_irq_t got, input clint_irq_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s got ms/mt/ss/st %b expected %b",
                               $time, what, got, exp));
  endtask

  //============================================================
  // Reference model
  //============================================================

  function automatic logic [31:0] map_addr(input int k);
    case (k)
      0:       return {16'h0, `CLINT_MSIP_ADDR};
      1:       return {16'h0, `CLINT_MTIMECMP_ADDR};
      2:       return {16'h0, `CLINT_MTIMECMPH_ADDR};
      3:       return {16'h0, `CLINT_MTIME_ADDR};
      4:       return {16'h0, `CLINT_MTIMEH_ADDR};
      5:       return {16'h0, `CLINT_SSIP_ADDR};
      6:       return {16'h0, `CLINT_STIMECMP_ADDR};
      default: return {16'h0, `CLINT_STIMECMPH_ADDR};
    endcase
  endfunction

  // Offsets live on paddr[15:0]
  function automatic clint_reg_e ref_decode(input logic [31:0] addr);
    case (addr[15:0])
      `CLINT_MSIP_ADDR:      return REG_MSIP;
      `CLINT_MTIMECMP_ADDR:  return REG_MTIMECMP;
      `CLINT_MTIMECMPH_ADDR: return REG_MTIMECMPH;
      `CLINT_MTIME_ADDR:     return REG_MTIME;
      `CLINT_MTIMEH_ADDR:    return REG_MTIMEH;
      `CLINT_SSIP_ADDR:      return REG_SSIP;
      `CLINT_STIMECMP_ADDR:  return REG_STIMECMP;
      `CLINT_STIMECMPH_ADDR: return REG_STIMECMPH;
      default:               return REG_NONE;
    endcase
  endfunction

  // pprot 11 machine, 00 user, else supervisor rights
  function automatic logic ref_err(input clint_reg_e idx, input logic [1:0] prot);
    case (idx)
      REG_MSIP, REG_MTIMECMP, REG_MTIMECMPH, REG_MTIME, REG_MTIMEH:
        return (prot != 2'b11);
      REG_SSIP, REG_STIMECMP, REG_STIMECMPH:
        return (prot == 2'b00);
      default:
        return 1'b1;
    endcase
  endfunction

  // Expected response, read word from the shadow registers
  function automatic apb_rsp_t ref_rsp(input logic [31:0] addr, input logic [1:0] prot);
    apb_rsp_t   r;
    clint_reg_e idx;
    idx       = ref_decode(addr);
    r.pready  = 1'b1;
    r.pslverr = ref_err(idx, prot);
    r.prdata  = 32'h0;
    if (!r.pslverr)
    begin
      case (idx)
        REG_MSIP:      r.prdata = {31'h0, sh_msip};
        REG_SSIP:      r.prdata = {31'h0, sh_ssip};
        REG_MTIMECMP:  r.prdata = sh_mcmp[31:0];
        REG_MTIMECMPH: r.prdata = sh_mcmp[63:32];
        REG_STIMECMP:  r.prdata = sh_scmp[31:0];
        REG_STIMECMPH: r.prdata = sh_scmp[63:32];
        default:       r.prdata = 32'h0;
      endcase
    end
    return r;
  endfunction

  //============================================================
  // APB driver
  //============================================================

  task automatic apb_xfer(input logic [31:0] addr, input logic [1:0] prot, input logic write,
                          input logic [31:0] wdata, output apb_rsp_t rsp);
    clint_reg_e idx;
    logic       err;
    idx    = ref_decode(addr);
    err    = ref_err(idx, prot);
    // Setup
    @(posedge clint_clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, pprot: prot,
                 paddr: addr, pwdata: wdata};
    // No response yet in the setup cycle
    @(negedge clint_clk);
    check_rsp(apb_rsp, '0, 1'b0, $sformatf("setup cycle to address %08h", addr));
    // Access
    @(posedge clint_clk);
    apb_req.penable <= 1'b1;
    // Two-cycle latency, response sampled mid access
    @(negedge clint_clk);
    rsp = apb_rsp;
    // Edge ending the access, the write lands here
    @(posedge clint_clk);
    apb_req <= '0;
    if (write && !err)
    begin
      case (idx)
        REG_MSIP:      sh_msip = wdata[0];
        REG_SSIP:      sh_ssip = wdata[0];
        REG_MTIMECMP:  sh_mcmp[31:0] = wdata;
        REG_MTIMECMPH: sh_mcmp[63:32] = wdata;
        REG_STIMECMP:  sh_scmp[31:0] = wdata;
        REG_STIMECMPH: sh_scmp[63:32] = wdata;
        default:
        begin
          mtime_wr_cnt++;
          mtime_wr_cycle = cycle_cnt;
        end
      endcase
    end
  endtask

  // mtime read data is checked by bounds elsewhere
  task automatic access_and_check(input logic [31:0] addr, input logic [1:0] prot,
                                  input logic write, input logic [31:0] wdata);
    apb_rsp_t   exp;
    apb_rsp_t   got;
    clint_reg_e idx;
    idx = ref_decode(addr);
    exp = ref_rsp(addr, prot);
    apb_xfer(addr, prot, write, wdata, got);
    check_rsp(got, exp, !write && (exp.pslverr || (idx != REG_MTIME && idx != REG_MTIMEH)),
              $sformatf("%s %08h prot %b", write ? "write" : "read", addr, prot));
  endtask

  //============================================================
  // Per-cycle interrupt compare
  //============================================================

  logic        prev_valid = 1'b0;
  logic        p_msip;
  logic        p_ssip;
  logic [63:0] p_time;
  logic [63:0] p_mcmp;
  logic [63:0] p_scmp;
  int unsigned p_wr_cnt;

  always @(negedge clint_clk)
  begin : irq_compare
    clint_irq_t exp;
    if (!cpurst_b)
    begin
      // Lines settle once the first clock edge has passed
      if (cycle_cnt != 0)
      begin
        exp = '0;
        check_irq(irq, exp, "irq during reset");
      end
      prev_valid = 1'b0;
    end
    else
    begin
      if (prev_valid)
      begin
        exp.ms = p_msip;
        exp.ss = p_ssip;
        exp.mt = (p_time >= p_mcmp);
        exp.st = (p_time >= p_scmp);
        check_irq(irq, exp, "irq lines");
        // Time only goes back through a bus load
        if (mtime_wr_cnt == p_wr_cnt && clint_time < p_time)
          report_failure($sformatf("Mismatch at %0t: clint_time fell from %016h to %016h",
                                   $time, p_time, clint_time));
      end
      p_msip     = sh_msip;
      p_ssip     = sh_ssip;
      p_time     = clint_time;
      p_mcmp     = sh_mcmp;
      p_scmp     = sh_scmp;
      p_wr_cnt   = mtime_wr_cnt;
      prev_valid = 1'b1;
    end
  end

  //============================================================
  // Watchdog
  //============================================================

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clint_clk);
    report_failure($sformatf("Timeout: the run did not finish within %0d clock cycles",
                             WATCHDOG_CYCLES));
  end

  //============================================================
  // Test sequence
  //============================================================

  initial
  begin : stimulus
    apb_rsp_t        got;
    logic [31:0]     r;
    logic [31:0]     addr;
    logic [31:0]     lo;
    logic [31:0]     hi;
    clint_reg_e      idx;
    int              waited;
    longint unsigned upper;
    apb_req = '0;
    @(posedge cpurst_b);
    @(posedge clint_clk);

    // Reset values, machine mode reads of every register
    check_irq(irq, '0, "irq after reset");
    for (int k = 0; k < 8; k++)
      access_and_check(map_addr(k), 2'b11, 1'b0, 32'h0);

    // Random addresses and privilege levels
    for (int n = 0; n < 60; n++)
    begin
      r = $random(seed);
      if (r[0])
      begin
        addr = map_addr(int'($unsigned($random(seed)) % 8));
        addr[31:16] = r[31:16];
      end
      else
        addr = $random(seed);
      r = $random(seed);
      access_and_check(addr, r[1:0], r[2], $random(seed));
      idx = ref_decode(addr);
      // Errored write must leave the register as it was
      if (r[2] && ref_err(idx, r[1:0]) && idx != REG_NONE
          && idx != REG_MTIME && idx != REG_MTIMEH)
        access_and_check(addr, 2'b11, 1'b0, 32'h0);
    end

    // Software interrupts
    access_and_check(map_addr(0), 2'b11, 1'b1, 32'h1);
    repeat (2) @(negedge clint_clk);
    check_word({31'h0, irq.ms}, 32'h1, "ms after msip set");
    access_and_check(map_addr(0), 2'b01, 1'b1, 32'h0);
    access_and_check(map_addr(5), 2'b01, 1'b1, 32'h1);
    repeat (2) @(negedge clint_clk);
    check_word({30'h0, irq.ms, irq.ss}, 32'h3, "ms/ss after ssip set");
    access_and_check(map_addr(0), 2'b11, 1'b1, 32'h0);
    access_and_check(map_addr(5), 2'b11, 1'b1, 32'h0);
    repeat (2) @(negedge clint_clk);
    check_word({30'h0, irq.ms, irq.ss}, 32'h0, "ms/ss after clear");

    // Timer interrupts, compares a few ticks ahead of mtime
    for (int n = 0; n < 3; n++)
    begin
      lo = $random(seed) & 32'h0FFF_FFFF;
      r  = $random(seed);
      access_and_check(map_addr(2), 2'b11, 1'b1, 32'h0);
      access_and_check(map_addr(1), 2'b11, 1'b1, lo + 32'd24 + {28'h0, r[3:0]});
      access_and_check(map_addr(7), 2'b01, 1'b1, 32'h0);
      access_and_check(map_addr(6), 2'b01, 1'b1, lo + 32'd8 + {28'h0, r[7:4]});
      access_and_check(map_addr(3), 2'b11, 1'b1, lo);
      access_and_check(map_addr(4), 2'b11, 1'b1, 32'h0);
      waited = 0;
      while (!(irq.mt && irq.st))
      begin
        waited++;
        if (waited > RISE_LIMIT)
          report_failure("Timer interrupt lines did not rise after mtime passed the compares");
        @(negedge clint_clk);
      end
    end

    // mtime counting after a load
    for (int n = 0; n < 4; n++)
    begin
      hi = $random(seed) & 32'h0000_00FF;
      lo = $random(seed) & 32'h0FFF_FFFF;
      // Low half cleared first so no carry reaches the high half
      access_and_check(map_addr(3), 2'b11, 1'b1, 32'h0);
      access_and_check(map_addr(4), 2'b11, 1'b1, hi);
      access_and_check(map_addr(3), 2'b11, 1'b1, lo);
      r = $random(seed);
      repeat (10 + int'(r[5:0])) @(posedge clint_clk);
      apb_xfer(map_addr(3), 2'b11, 1'b0, 32'h0, got);
      upper = longint'(lo) + (cycle_cnt - mtime_wr_cycle) / TICK_DIV + 1;
      if (got.prdata < lo || longint'(got.prdata) > upper)
        report_failure($sformatf("Mismatch at %0t: mtime low %08h outside %08h..%08h",
                                 $time, got.prdata, lo, upper[31:0]));
      apb_xfer(map_addr(4), 2'b11, 1'b0, 32'h0, got);
      check_word(got.prdata, hi, "mtime high half");
    end

    repeat (4) @(posedge clint_clk);
    $display("Test OK");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/clint_pkg.sv
hdl/clint_apb_fsm.sv
hdl/clint_mtime_counter.sv
hdl/clint_regfile.sv
hdl/clint_irq_gen.sv
hdl/clint_top.sv
testbench/tb_clk_gen.sv
testbench/clint_tb.sv

// ==== Makefile ====
# Verilator flow for the CLINT testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --sv --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status
sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
